// File: common/coh_config.svh
`ifndef COH_CONFIG_SVH
`define COH_CONFIG_SVH

// Cache geometry, direct mapped
`define COH_NUM_LINES    8
`define COH_BLOCK_WORDS  2
`define COH_INDEX_BITS   3
`define COH_TAG_BITS     26

// Main memory
`define COH_MEM_WORDS    1024
`define COH_MEM_LATENCY  4

`endif

// File: common/coh_pkg.sv
package coh_pkg;

`include "coh_config.svh"

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;                        // [2] word, [5:3] index, [31:6] tag
    typedef word_t [`COH_BLOCK_WORDS-1:0] block_t;

    typedef enum logic [1:0] {MESI_I, MESI_S, MESI_E, MESI_M} mesi_e;

    typedef enum logic [1:0] {BUS_RD, BUS_RDX, BUS_UPGR, BUS_WB} bus_cmd_e;

    typedef enum logic [1:0] {BUS_IDLE, BUS_SNOOP, BUS_MEM, BUS_DONE} bus_state_e;

    typedef enum logic [1:0] {C_SWEEP, C_IDLE, C_WB, C_MISS} cache_state_e;

    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } proc_req_t;

    typedef struct packed {
        word_t rdata;
        logic  busy;
        logic  init_done;
    } proc_resp_t;

    typedef struct packed {
        logic     valid;
        bus_cmd_e cmd;
        addr_t    addr;                                 // Block aligned
        block_t   wb_data;
    } bus_req_t;

    typedef struct packed {
        logic   done;
        block_t data;
        logic   shared;
    } bus_resp_t;

    typedef struct packed {
        logic     valid;
        bus_cmd_e cmd;
        addr_t    addr;
    } snoop_req_t;

    typedef struct packed {
        logic   hit;
        logic   dirty;
        block_t data;
    } snoop_resp_t;

    typedef struct packed {
        logic   valid;
        logic   we;
        addr_t  addr;
        block_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic   done;
        block_t rdata;
    } mem_resp_t;

endpackage

// File: cache/line_sweep.sv
`timescale 1ns/1ps
`include "coh_config.svh"

module line_sweep (
    input  logic                       CLK,
    input  logic                       rst_n,
    output logic                       inv_en,
    output logic [`COH_INDEX_BITS-1:0] inv_index,
    output logic                       init_done
);
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            inv_index <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            if (inv_index == `COH_INDEX_BITS'(`COH_NUM_LINES - 1)) begin
                init_done <= 1'b1;                      // Last line cleared this edge
            end else begin
                inv_index <= inv_index + 1'b1;
            end
        end
    end

    assign inv_en = !init_done;

endmodule

// File: cache/l1_line_array.sv
`timescale 1ns/1ps
`include "coh_config.svh"

module l1_line_array
    import coh_pkg::*;
(
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic [`COH_INDEX_BITS-1:0] rd_index,
    output logic [`COH_TAG_BITS-1:0]   tag_out,
    output mesi_e                      state_out,
    output block_t                     data_out,
    input  logic                       wr_en,
    input  logic [`COH_INDEX_BITS-1:0] wr_index,
    input  logic [`COH_TAG_BITS-1:0]   wr_tag,
    input  mesi_e                      wr_state,
    input  block_t                     wr_data,
    input  addr_t                      snp_addr,
    output logic                       snp_hit,
    output mesi_e                      snp_state,
    output block_t                     snp_data,
    input  logic                       snp_state_wr_en,
    input  mesi_e                      snp_new_state,
    input  logic                       inv_en,
    input  logic [`COH_INDEX_BITS-1:0] inv_index
);
    localparam int IDX_LO = 2 + $clog2(`COH_BLOCK_WORDS);

    logic [`COH_TAG_BITS-1:0]   tags   [`COH_NUM_LINES];
    mesi_e                      states [`COH_NUM_LINES];
    block_t                     blocks [`COH_NUM_LINES];
    logic [`COH_INDEX_BITS-1:0] snp_index;

    assign tag_out   = tags[rd_index];
    assign state_out = states[rd_index];
    assign data_out  = blocks[rd_index];

    assign snp_index = snp_addr[IDX_LO +: `COH_INDEX_BITS];
    assign snp_state = states[snp_index];
    assign snp_data  = blocks[snp_index];
    assign snp_hit   = snp_state != MESI_I && tags[snp_index] == snp_addr[31 -: `COH_TAG_BITS];

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            tags[wr_index]   <= wr_tag;
            blocks[wr_index] <= wr_data;
        end
    end

    // Sweep has priority, valid bits are garbage until it finishes
    always_ff @(posedge CLK) begin
        if (inv_en) begin
            states[inv_index] <= MESI_I;
        end else begin
            if (wr_en) states[wr_index] <= wr_state;
            if (snp_state_wr_en) states[snp_index] <= snp_new_state;
        end
    end

    assert property (@(posedge CLK) disable iff (!rst_n)
        !(wr_en && snp_state_wr_en && wr_index == snp_index));

endmodule

// File: cache/l1_cache.sv
`timescale 1ns/1ps
`include "coh_config.svh"

module l1_cache
    import coh_pkg::*;
(
    input  logic        CLK,
    input  logic        rst_n,
    input  proc_req_t   proc_req,
    output proc_resp_t  proc_resp,
    output bus_req_t    bus_req,
    input  bus_resp_t   bus_resp,
    input  snoop_req_t  snoop_req,
    output snoop_resp_t snoop_resp
);
    localparam int OFF_BITS = $clog2(`COH_BLOCK_WORDS);
    localparam int IDX_LO   = 2 + OFF_BITS;

    cache_state_e               state;
    logic [`COH_INDEX_BITS-1:0] index;
    logic [`COH_INDEX_BITS-1:0] inv_index;
    logic [`COH_TAG_BITS-1:0]   tag;
    logic [`COH_TAG_BITS-1:0]   tag_out;
    logic [OFF_BITS-1:0]        offset;
    mesi_e                      state_out;
    mesi_e                      snp_state;
    mesi_e                      wr_state;
    block_t                     data_out;
    block_t                     snp_data;
    block_t                     base_data;
    block_t                     line_wdata;
    bus_cmd_e                   miss_cmd;
    logic                       pending;
    logic                       tag_hit;
    logic                       hit;
    logic                       snoop_block;
    logic                       hit_done;
    logic                       fill_done;
    logic                       wr_en;
    logic                       snp_hit;
    logic                       inv_en;
    logic                       init_done;

    assign index   = proc_req.addr[IDX_LO +: `COH_INDEX_BITS];
    assign tag     = proc_req.addr[31 -: `COH_TAG_BITS];
    assign offset  = proc_req.addr[2 +: OFF_BITS];
    assign pending = proc_req.ren || proc_req.wen;
    assign tag_hit = state_out != MESI_I && tag_out == tag;

    // Writes need ownership, reads take any valid copy
    assign hit = proc_req.wen ? tag_hit && state_out inside {MESI_E, MESI_M} : tag_hit;

    // A snoop on our index this cycle may change the line under us
    assign snoop_block = snoop_req.valid && snoop_req.addr[IDX_LO +: `COH_INDEX_BITS] == index;
    assign hit_done    = state == C_IDLE && pending && hit && !snoop_block;
    assign fill_done   = state == C_MISS && bus_resp.done;

    always_comb begin
        if (!proc_req.wen) begin
            miss_cmd = BUS_RD;
        end else if (tag_hit) begin
            miss_cmd = BUS_UPGR;                        // Line still held in S
        end else begin
            miss_cmd = BUS_RDX;
        end
    end

    // Fill data, or the line itself for a hit or an upgrade
    assign base_data = (state == C_IDLE || miss_cmd == BUS_UPGR) ? data_out : bus_resp.data;

    always_comb begin
        line_wdata = base_data;
        if (proc_req.wen) begin
            line_wdata[offset] = proc_req.wdata;
        end
    end

    assign wr_en = (hit_done && proc_req.wen) || fill_done;

    always_comb begin
        if (!fill_done || proc_req.wen) begin
            wr_state = MESI_M;
        end else begin
            wr_state = bus_resp.shared ? MESI_S : MESI_E;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= C_SWEEP;
        end else begin
            case (state)
                C_SWEEP: if (init_done) state <= C_IDLE;
                C_IDLE: begin
                    if (pending && !hit && !snoop_block) begin
                        // Dirty victim goes out before the fill
                        state <= (state_out == MESI_M && !tag_hit) ? C_WB : C_MISS;
                    end
                end
                C_WB: if (state_out != MESI_M || bus_resp.done) state <= C_MISS;
                default: if (bus_resp.done) state <= C_IDLE;
            endcase
        end
    end

    assign bus_req = '{
        valid:   (state == C_WB && state_out == MESI_M) || state == C_MISS,
        cmd:     (state == C_WB) ? BUS_WB : miss_cmd,
        addr:    {(state == C_WB) ? tag_out : tag, index, {IDX_LO{1'b0}}},
        wb_data: data_out
    };

    // Ready is reported once the controller has left the sweep
    assign proc_resp = '{
        rdata:     data_out[offset],
        busy:      !(state == C_IDLE && (!pending || (hit && !snoop_block))),
        init_done: state != C_SWEEP
    };

    assign snoop_resp = '{
        hit:   snoop_req.valid && snp_hit,
        dirty: snoop_req.valid && snp_hit && snp_state == MESI_M,
        data:  snp_data
    };

    l1_line_array u_line_array (
        .CLK             (CLK),
        .rst_n           (rst_n),
        .rd_index        (index),
        .tag_out         (tag_out),
        .state_out       (state_out),
        .data_out        (data_out),
        .wr_en           (wr_en),
        .wr_index        (index),
        .wr_tag          (tag),
        .wr_state        (wr_state),
        .wr_data         (line_wdata),
        .snp_addr        (snoop_req.addr),
        .snp_hit         (snp_hit),
        .snp_state       (snp_state),
        .snp_data        (snp_data),
        .snp_state_wr_en (snoop_resp.hit),
        .snp_new_state   ((snoop_req.cmd == BUS_RD) ? MESI_S : MESI_I),
        .inv_en          (inv_en),
        .inv_index       (inv_index)
    );

    line_sweep u_line_sweep (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .inv_en    (inv_en),
        .inv_index (inv_index),
        .init_done (init_done)
    );

    assert property (@(posedge CLK) disable iff (!rst_n)
        state inside {C_IDLE, C_SWEEP} |-> !bus_req.valid);

    // The bus only completes a request we are still holding
    assert property (@(posedge CLK) disable iff (!rst_n)
        bus_resp.done |-> bus_req.valid);

endmodule

// File: design/coherence_bus.sv
`timescale 1ns/1ps

module coherence_bus
    import coh_pkg::*;
(
    input  logic        CLK,
    input  logic        rst_n,
    input  bus_req_t    req0,
    input  bus_req_t    req1,
    output bus_resp_t   resp0,
    output bus_resp_t   resp1,
    output snoop_req_t  snp0,
    output snoop_req_t  snp1,
    input  snoop_resp_t snpr0,
    input  snoop_resp_t snpr1,
    output mem_req_t    mem_req,
    input  mem_resp_t   mem_resp
);
    bus_state_e  state;
    logic        owner;                                 // Last granted cache
    logic        gnt_pick;
    bus_cmd_e    cmd_q;
    addr_t       addr_q;
    block_t      wbd_q;
    block_t      fill_q;
    logic        hit_q;
    logic        dirty_q;
    snoop_resp_t snpr;
    logic        snp_en;
    logic        mem_we;

    // Round robin on a tie, otherwise whoever asks
    assign gnt_pick = (req0.valid && req1.valid) ? !owner : req1.valid;

    assign snpr   = owner ? snpr0 : snpr1;              // Answer from the other cache
    assign snp_en = state == BUS_SNOOP && cmd_q != BUS_WB;
    assign mem_we = cmd_q == BUS_WB || dirty_q;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state   <= BUS_IDLE;
            owner   <= 1'b1;                            // Cache 0 wins the first tie
            hit_q   <= 1'b0;
            dirty_q <= 1'b0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (req0.valid || req1.valid) begin
                        owner <= gnt_pick;
                        state <= BUS_SNOOP;
                    end
                end
                BUS_SNOOP: begin
                    hit_q   <= snpr.hit;
                    dirty_q <= snpr.dirty;
                    // Clean copies come from the other cache, upgrades need no data
                    if (snpr.dirty || (cmd_q != BUS_UPGR && !snpr.hit)) begin
                        state <= BUS_MEM;
                    end else begin
                        state <= BUS_DONE;
                    end
                end
                BUS_MEM: if (mem_resp.done) state <= BUS_DONE;
                default: state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == BUS_IDLE) begin
            cmd_q  <= gnt_pick ? req1.cmd : req0.cmd;
            addr_q <= gnt_pick ? req1.addr : req0.addr;
            wbd_q  <= gnt_pick ? req1.wb_data : req0.wb_data;
        end
        if (state == BUS_SNOOP) begin
            fill_q <= snpr.data;
        end
        if (state == BUS_MEM && mem_resp.done && !mem_we) begin
            fill_q <= mem_resp.rdata;
        end
    end

    assign snp0 = '{valid: snp_en && owner, cmd: cmd_q, addr: addr_q};
    assign snp1 = '{valid: snp_en && !owner, cmd: cmd_q, addr: addr_q};

    assign resp0 = '{done: state == BUS_DONE && !owner, data: fill_q, shared: hit_q};
    assign resp1 = '{done: state == BUS_DONE && owner, data: fill_q, shared: hit_q};

    // Dirty snoop data goes to memory and to the requester
    assign mem_req = '{
        valid: state == BUS_MEM,
        we:    mem_we,
        addr:  addr_q,
        wdata: (cmd_q == BUS_WB) ? wbd_q : fill_q
    };

    assert property (@(posedge CLK) disable iff (!rst_n)
        !(snp0.valid && snp1.valid));

    assert property (@(posedge CLK) disable iff (!rst_n)
        $onehot0({resp0.done, resp1.done}));

endmodule

// File: design/main_memory.sv
`timescale 1ns/1ps
`include "coh_config.svh"

module main_memory
    import coh_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  mem_req_t  mem_req,
    output mem_resp_t mem_resp
);
    localparam int WORD_BITS = $clog2(`COH_MEM_WORDS);
    localparam int OFF_BITS  = $clog2(`COH_BLOCK_WORDS);
    localparam int CNT_BITS  = $clog2(`COH_MEM_LATENCY) + 1;

    word_t                         mem [`COH_MEM_WORDS] = '{default: '0};
    logic [CNT_BITS-1:0]           lat_cnt;
    logic [WORD_BITS-OFF_BITS-1:0] blk;
    logic                          last;
    logic                          done_q;
    block_t                        rdata_q;

    assign blk  = mem_req.addr[WORD_BITS+1:OFF_BITS+2];
    assign last = mem_req.valid && !done_q && lat_cnt == CNT_BITS'(`COH_MEM_LATENCY - 1);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            lat_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= last;
            if (last) begin
                lat_cnt <= '0;
            end else if (mem_req.valid && !done_q) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    // Whole block moves on the final latency cycle
    always_ff @(posedge CLK) begin
        if (last) begin
            for (int w = 0; w < `COH_BLOCK_WORDS; w++) begin
                if (mem_req.we) mem[{blk, OFF_BITS'(w)}] <= mem_req.wdata[w];
                rdata_q[w] <= mem[{blk, OFF_BITS'(w)}];
            end
        end
    end

    assign mem_resp = '{done: done_q, rdata: rdata_q};

    assert property (@(posedge CLK) disable iff (!rst_n)
        mem_req.valid && !done_q |=> mem_req.valid && $stable(mem_req.addr));

endmodule

// File: design/two_cache_coh.sv
`timescale 1ns/1ps

module two_cache_coh
    import coh_pkg::*;
(
    input  logic       CLK,
    input  logic       rst_n,
    input  proc_req_t  proc0_req,
    output proc_resp_t proc0_resp,
    input  proc_req_t  proc1_req,
    output proc_resp_t proc1_resp
);
    bus_req_t    bus_req0;
    bus_req_t    bus_req1;
    bus_resp_t   bus_resp0;
    bus_resp_t   bus_resp1;
    snoop_req_t  snp0;
    snoop_req_t  snp1;
    snoop_resp_t snpr0;
    snoop_resp_t snpr1;
    mem_req_t    mem_req;
    mem_resp_t   mem_resp;

    l1_cache u_cache0 (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .proc_req   (proc0_req),
        .proc_resp  (proc0_resp),
        .bus_req    (bus_req0),
        .bus_resp   (bus_resp0),
        .snoop_req  (snp0),
        .snoop_resp (snpr0)
    );

    l1_cache u_cache1 (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .proc_req   (proc1_req),
        .proc_resp  (proc1_resp),
        .bus_req    (bus_req1),
        .bus_resp   (bus_resp1),
        .snoop_req  (snp1),
        .snoop_resp (snpr1)
    );

    coherence_bus u_bus (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .req0     (bus_req0),
        .req1     (bus_req1),
        .resp0    (bus_resp0),
        .resp1    (bus_resp1),
        .snp0     (snp0),
        .snp1     (snp1),
        .snpr0    (snpr0),
        .snpr1    (snpr1),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    main_memory u_memory (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

endmodule

// File: verification/tb_two_cache_coh.sv
`timescale 1ns/1ps
`include "coh_config.svh"

module tb_two_cache_coh
    import coh_pkg::*;
();
    localparam int    ACCESS_TIMEOUT = 200;                 // Cycles per processor access
    localparam int    INIT_TIMEOUT   = `COH_NUM_LINES + 20;
    localparam addr_t MIX_BASE       = 32'h0000_0400;       // 16-word random window

    logic       CLK;
    logic       rst_n;
    proc_req_t  proc0_req;
    proc_req_t  proc1_req;
    proc_resp_t proc0_resp;
    proc_resp_t proc1_resp;

    word_t  model [addr_t];                                 // Expected memory contents
    int     mismatches = 0;
    int     timeouts   = 0;
    integer seed       = 32'h56f0_3daa;

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    two_cache_coh u_two_cache_coh (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .proc0_req  (proc0_req),
        .proc0_resp (proc0_resp),
        .proc1_req  (proc1_req),
        .proc1_resp (proc1_resp)
    );

    function automatic word_t expected(addr_t addr);
        if (model.exists(addr)) return model[addr];
        return '0;                                          // Memory starts zeroed
    endfunction

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            mismatches++;
            $display("** Error at time %0t: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            mismatches++;
            $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Holds the request as a level until busy drops, sampled mid-cycle
    task automatic access(input int port, input logic we, input addr_t addr,
                          input word_t wdata, output word_t rdata);
        proc_req_t  req;
        proc_resp_t resp;
        int         cnt;
        bit         done;
        req   = '{ren: !we, wen: we, addr: addr, wdata: wdata};
        cnt   = 0;
        done  = 1'b0;
        rdata = '0;
        @(posedge CLK);
        #1;
        if (port == 0) proc0_req = req;
        else proc1_req = req;
        while (!done && cnt < ACCESS_TIMEOUT) begin
            @(negedge CLK);
            resp = (port == 0) ? proc0_resp : proc1_resp;
            if (!resp.busy) begin
                done  = 1'b1;
                rdata = resp.rdata;
            end
            cnt++;
        end
        if (!done) begin
            $display("Timeout: port %0d access to %h never completed", port, addr);
            timeouts++;
            finish_run();
        end else begin
            @(posedge CLK);                                 // Write lands at this edge
            #1;
            if (port == 0) proc0_req = '0;
            else proc1_req = '0;
        end
    endtask

    task automatic do_read(int port, addr_t addr);
        word_t got;
        access(port, 1'b0, addr, '0, got);
        check_word(got, expected(addr), $sformatf("port %0d read of %h", port, addr));
    endtask

    task automatic do_write(int port, addr_t addr, word_t data);
        word_t unused;
        access(port, 1'b1, addr, data, unused);
        model[addr] = data;
    endtask

    task automatic reset_check();
        int cnt;
        cnt = 0;
        @(negedge CLK);
        check_bit(proc0_resp.busy, 1'b1, "port 0 busy during sweep");
        check_bit(proc1_resp.init_done, 1'b0, "port 1 init_done during sweep");
        while (!(proc0_resp.init_done && proc1_resp.init_done) && cnt < INIT_TIMEOUT) begin
            @(negedge CLK);
            cnt++;
        end
        if (!(proc0_resp.init_done && proc1_resp.init_done)) begin
            $display("Timeout: init_done did not rise on both caches after reset");
            timeouts++;
            finish_run();
        end else begin
            check_bit(proc0_resp.busy, 1'b0, "port 0 busy when idle");
            check_bit(proc1_resp.busy, 1'b0, "port 1 busy when idle");
            do_read(0, 32'h0000_0100);
            do_read(1, 32'h0000_0204);
        end
    endtask

    task automatic dirty_supply();
        do_write(0, 32'h8000_0000, $random(seed));
        do_read(1, 32'h8000_0000);                          // Comes from cache 0 in M
        do_read(0, 32'h8000_0000);
    endtask

    task automatic shared_fill();
        do_read(0, 32'h0000_0040);                          // Clean miss, installs E
        do_write(0, 32'h0000_0040, $random(seed));
        do_write(0, 32'h0000_0044, $random(seed));
        do_read(1, 32'h0000_0040);
        do_read(1, 32'h0000_0044);
    endtask

    task automatic ping_pong();
        for (int i = 0; i < 8; i++) begin
            do_write(i % 2, 32'h0000_0080, 32'h1000_0000 + i);
            do_read((i + 1) % 2, 32'h0000_0080);
        end
    endtask

    task automatic eviction();
        addr_t addr;
        for (int i = 0; i < 3; i++) begin
            addr = 32'h0000_0304 + 64 * i;                  // All map to index 0
            do_write(0, addr, $random(seed));
        end
        for (int i = 0; i < 3; i++) begin
            do_read(0, 32'h0000_0304 + 64 * i);
        end
        for (int i = 0; i < 3; i++) begin
            do_read(1, 32'h0000_0304 + 64 * i);
        end
    endtask

    task automatic issue_op(int port, logic we, addr_t addr, word_t data);
        if (we) do_write(port, addr, data);
        else do_read(port, addr);
    endtask

    task automatic random_mix();
        int    w0;
        int    w1;
        logic  we0;
        logic  we1;
        word_t d0;
        word_t d1;
        for (int i = 0; i < 100; i++) begin
            w0  = $unsigned($random(seed)) % 16;
            w1  = (w0 + 1 + $unsigned($random(seed)) % 15) % 16;   // Never the same word
            we0 = $random(seed);
            we1 = $random(seed);
            d0  = $random(seed);
            d1  = $random(seed);
            fork
                issue_op(0, we0, MIX_BASE + 4 * w0, d0);
                issue_op(1, we1, MIX_BASE + 4 * w1, d1);
            join
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        proc0_req = '0;
        proc1_req = '0;
        repeat (4) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        reset_check();
        dirty_supply();
        shared_fill();
        ping_pong();
        eviction();
        random_mix();
        finish_run();
    end

endmodule

// File: compile.f
+incdir+common
common/coh_pkg.sv
cache/line_sweep.sv
cache/l1_line_array.sv
cache/l1_cache.sv
design/coherence_bus.sv
design/main_memory.sv
design/two_cache_coh.sv
verification/tb_two_cache_coh.sv

// File: Bender.yml
package:
  name: two_cache_coh

export_include_dirs:
  - common

sources:
  - common/coh_pkg.sv
  - cache/line_sweep.sv
  - cache/l1_line_array.sv
  - cache/l1_cache.sv
  - design/coherence_bus.sv
  - design/main_memory.sv
  - design/two_cache_coh.sv
  - target: simulation
    files:
      - verification/tb_two_cache_coh.sv
